//--- rtl/wb_pkg.sv
package wb_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [13:0] csr_num_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;

    // one instruction leaving mem.
    typedef struct packed {
        // register write.
        logic      gr_we;
        word_t     pc;
        word_t     inst;
        word_t     final_result;
        reg_addr_t dest;
        // csr access.
        logic      csr_we;
        logic      csr_re;
        csr_num_t  csr_num;
        word_t     csr_wmask;
        word_t     csr_wvalue;
        // trap.
        logic      ex;
        ecode_t    ecode;
        esubcode_t esubcode;
        logic      ertn;
    } mem_wb_bus_t;

    // forwarding back to decode.
    typedef struct packed {
        logic      rf_we;
        reg_addr_t rf_waddr;
        word_t     rf_wdata;
    } wb_id_bus_t;

    typedef struct packed {
        csr_num_t num;
        logic     re;    // set for any access, writes return the old value.
        logic     we;
        word_t    wmask;
        word_t    wvalue;
    } csr_req_t;

    // csr numbers.
    localparam csr_num_t csr_crmd   = 14'h000;
    localparam csr_num_t csr_prmd   = 14'h001;
    localparam csr_num_t csr_estat  = 14'h005;
    localparam csr_num_t csr_era    = 14'h006;
    localparam csr_num_t csr_eentry = 14'h00c;
    localparam csr_num_t csr_save0  = 14'h030;

    // crmd and prmd share the plv/ie layout in the low bits.
    localparam int crmd_plv_lsb = 0;
    localparam int crmd_ie_bit  = 2;
    localparam int crmd_da_bit  = 3;

    // estat exception cause fields.
    localparam int estat_ecode_lsb    = 16;
    localparam int estat_esubcode_lsb = 22;

    // eentry is page aligned to 64 bytes.
    localparam int eentry_va_lsb = 6;

endpackage

//--- rtl/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  logic                clk,
    input  logic                resetn,

    input  logic                mem_wb_valid,
    input  wb_pkg::mem_wb_bus_t mem_wb_bus,
    output logic                wb_allowin,

    output wb_pkg::wb_id_bus_t  wb_id_bus,

    output logic                rf_we,
    output wb_pkg::reg_addr_t   rf_waddr,
    output wb_pkg::word_t       rf_wdata,

    output wb_pkg::csr_req_t    csr_req,
    input  wb_pkg::word_t       csr_rvalue,
    output logic                wb_ex,
    output logic                wb_ertn,
    output wb_pkg::word_t       wb_pc,
    output wb_pkg::ecode_t      wb_ecode,
    output wb_pkg::esubcode_t   wb_esubcode,

    output wb_pkg::word_t       debug_wb_pc,
    output logic [3:0]          debug_wb_rf_we,
    output wb_pkg::reg_addr_t   debug_wb_rf_wnum,
    output wb_pkg::word_t       debug_wb_rf_wdata
);
    import wb_pkg::*;

    logic        wb_valid;
    mem_wb_bus_t wb_bus;
    word_t       wb_wdata;

    assign wb_allowin = 1'b1;    // nothing in wb takes more than a cycle.

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (wb_allowin) begin
            wb_valid <= mem_wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wb_valid && wb_allowin) begin
            wb_bus <= mem_wb_bus;
        end
    end

    // a trapping instruction must not retire any state.
    assign rf_we    = wb_valid & wb_bus.gr_we & ~wb_bus.ex;
    assign rf_waddr = wb_bus.dest;
    assign wb_wdata = csr_req.re ? csr_rvalue : wb_bus.final_result;
    assign rf_wdata = wb_wdata;

    always_comb begin
        csr_req.num    = wb_bus.csr_num;
        csr_req.re     = wb_valid & (wb_bus.csr_re | wb_bus.csr_we);
        csr_req.we     = wb_valid & wb_bus.csr_we & ~wb_bus.ex;
        csr_req.wmask  = wb_bus.csr_wmask;
        csr_req.wvalue = wb_bus.csr_wvalue;
    end

    assign wb_ex       = wb_valid & wb_bus.ex;
    assign wb_ertn     = wb_valid & wb_bus.ertn;
    assign wb_pc       = wb_bus.pc;
    assign wb_ecode    = wb_bus.ecode;
    assign wb_esubcode = wb_bus.esubcode;

    always_comb begin
        wb_id_bus.rf_we    = rf_we;
        wb_id_bus.rf_waddr = rf_waddr;
        wb_id_bus.rf_wdata = wb_wdata;
    end

    assign debug_wb_pc       = wb_bus.pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = wb_bus.dest;
    assign debug_wb_rf_wdata = wb_wdata;

endmodule

//--- rtl/csr_file.sv
`timescale 1ns/1ps

module csr_file #(
    parameter int save_regs = 4
) (
    input  logic              clk,
    input  logic              resetn,

    input  wb_pkg::csr_req_t  csr_req,
    output wb_pkg::word_t     csr_rvalue,

    input  logic              wb_ex,
    input  logic              wb_ertn,
    input  wb_pkg::word_t     wb_pc,
    input  wb_pkg::ecode_t    wb_ecode,
    input  wb_pkg::esubcode_t wb_esubcode,

    output logic              flush,
    output wb_pkg::word_t     flush_pc
);
    import wb_pkg::*;

    logic [1:0]  crmd_plv;
    logic        crmd_ie;
    logic        crmd_da;
    logic [1:0]  prmd_pplv;
    logic        prmd_pie;
    ecode_t      estat_ecode;
    esubcode_t   estat_esubcode;
    word_t       era;
    logic [25:0] eentry_va;
    word_t       save_q [save_regs];

    word_t crmd_rd;
    word_t prmd_rd;
    word_t estat_rd;
    word_t eentry_rd;

    function automatic word_t masked(word_t old, word_t wmask, word_t wvalue);
        return (old & ~wmask) | (wvalue & wmask);
    endfunction

    // readable views; unimplemented bits are zero.
    always_comb begin
        crmd_rd = '0;
        crmd_rd[crmd_plv_lsb +: 2] = crmd_plv;
        crmd_rd[crmd_ie_bit] = crmd_ie;
        crmd_rd[crmd_da_bit] = crmd_da;
        prmd_rd = '0;
        prmd_rd[crmd_plv_lsb +: 2] = prmd_pplv;
        prmd_rd[crmd_ie_bit] = prmd_pie;
        estat_rd = '0;
        estat_rd[estat_ecode_lsb +: 6] = estat_ecode;
        estat_rd[estat_esubcode_lsb +: 9] = estat_esubcode;
        eentry_rd = {eentry_va, 6'b0};
    end

    function automatic logic hit(csr_req_t req, csr_num_t num);
        return req.we && req.num == num;
    endfunction

    // trap entry wins over ertn, which wins over a software write.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv <= 2'd0;
            crmd_ie  <= 1'b0;
            crmd_da  <= 1'b1;    // direct address mode out of reset.
        end else if (wb_ex) begin
            crmd_plv <= 2'd0;
            crmd_ie  <= 1'b0;
        end else if (wb_ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (hit(csr_req, csr_crmd)) begin
            crmd_plv <= masked(crmd_rd, csr_req.wmask, csr_req.wvalue)[crmd_plv_lsb +: 2];
            crmd_ie  <= masked(crmd_rd, csr_req.wmask, csr_req.wvalue)[crmd_ie_bit];
            crmd_da  <= masked(crmd_rd, csr_req.wmask, csr_req.wvalue)[crmd_da_bit];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            prmd_pplv <= 2'd0;
            prmd_pie  <= 1'b0;
        end else if (wb_ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (hit(csr_req, csr_prmd)) begin
            prmd_pplv <= masked(prmd_rd, csr_req.wmask, csr_req.wvalue)[crmd_plv_lsb +: 2];
            prmd_pie  <= masked(prmd_rd, csr_req.wmask, csr_req.wvalue)[crmd_ie_bit];
        end
    end

    // ecode and esubcode are read only to software.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end else if (wb_ex) begin
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            era <= '0;
        end else if (wb_ex) begin
            era <= wb_pc;
        end else if (hit(csr_req, csr_era)) begin
            era <= masked(era, csr_req.wmask, csr_req.wvalue);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            eentry_va <= '0;
        end else if (hit(csr_req, csr_eentry)) begin
            eentry_va <= masked(eentry_rd, csr_req.wmask, csr_req.wvalue)[31:eentry_va_lsb];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < save_regs; i++) begin
                save_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < save_regs; i++) begin
                if (hit(csr_req, csr_save0 + csr_num_t'(i))) begin
                    save_q[i] <= masked(save_q[i], csr_req.wmask, csr_req.wvalue);
                end
            end
        end
    end

    always_comb begin
        csr_rvalue = '0;    // unknown numbers read zero.
        case (csr_req.num)
            csr_crmd:   csr_rvalue = crmd_rd;
            csr_prmd:   csr_rvalue = prmd_rd;
            csr_estat:  csr_rvalue = estat_rd;
            csr_era:    csr_rvalue = era;
            csr_eentry: csr_rvalue = eentry_rd;
            default: begin
                for (int i = 0; i < save_regs; i++) begin
                    if (csr_req.num == csr_save0 + csr_num_t'(i)) begin
                        csr_rvalue = save_q[i];
                    end
                end
            end
        endcase
    end

    assign flush    = wb_ex | wb_ertn;
    assign flush_pc = wb_ex ? eentry_rd : era;

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,

    input  logic              we,
    input  wb_pkg::reg_addr_t waddr,
    input  wb_pkg::word_t     wdata,

    input  wb_pkg::reg_addr_t raddr1,
    output wb_pkg::word_t     rdata1,
    input  wb_pkg::reg_addr_t raddr2,
    output wb_pkg::word_t     rdata2
);
    import wb_pkg::*;

    word_t regs [32];

    // r0 is never written.
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // asynchronous read, so a write shows up the cycle after its edge.
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];    // hardwired zero.

endmodule

//--- rtl/wb_top.sv
`timescale 1ns/1ps

module wb_top #(
    parameter int save_regs = 4
) (
    input  logic                clk,
    input  logic                resetn,

    input  logic                mem_wb_valid,
    input  wb_pkg::mem_wb_bus_t mem_wb_bus,
    output logic                wb_allowin,

    output wb_pkg::wb_id_bus_t  wb_id_bus,

    input  wb_pkg::reg_addr_t   rf_raddr1,
    output wb_pkg::word_t       rf_rdata1,
    input  wb_pkg::reg_addr_t   rf_raddr2,
    output wb_pkg::word_t       rf_rdata2,

    output wb_pkg::word_t       debug_wb_pc,
    output logic [3:0]          debug_wb_rf_we,
    output wb_pkg::reg_addr_t   debug_wb_rf_wnum,
    output wb_pkg::word_t       debug_wb_rf_wdata,

    output logic                flush,
    output wb_pkg::word_t       flush_pc
);
    import wb_pkg::*;

    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;
    csr_req_t  csr_req;
    word_t     csr_rvalue;
    logic      wb_ex;
    logic      wb_ertn;
    word_t     wb_pc;
    ecode_t    wb_ecode;
    esubcode_t wb_esubcode;

    wb_stage i_wb_stage (
        .clk               (clk),
        .resetn            (resetn),
        .mem_wb_valid      (mem_wb_valid),
        .mem_wb_bus        (mem_wb_bus),
        .wb_allowin        (wb_allowin),
        .wb_id_bus         (wb_id_bus),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .csr_req           (csr_req),
        .csr_rvalue        (csr_rvalue),
        .wb_ex             (wb_ex),
        .wb_ertn           (wb_ertn),
        .wb_pc             (wb_pc),
        .wb_ecode          (wb_ecode),
        .wb_esubcode       (wb_esubcode),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    csr_file #(
        .save_regs (save_regs)
    ) i_csr_file (
        .clk         (clk),
        .resetn      (resetn),
        .csr_req     (csr_req),
        .csr_rvalue  (csr_rvalue),
        .wb_ex       (wb_ex),
        .wb_ertn     (wb_ertn),
        .wb_pc       (wb_pc),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .flush       (flush),
        .flush_pc    (flush_pc)
    );

    reg_file i_reg_file (
        .clk    (clk),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (rf_raddr1),
        .rdata1 (rf_rdata1),
        .raddr2 (rf_raddr2),
        .rdata2 (rf_rdata2)
    );

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;    // 8 ns period.
    end

    initial begin
        resetn = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        resetn = 1'b1;    // released 1 ns after the edge.
    end

endmodule

//--- test/wb_top_sva.sv
`timescale 1ns/1ps

module wb_top_sva (
    input logic          clk,
    input logic          resetn,
    input logic          wb_allowin,
    input logic [3:0]    debug_wb_rf_we,
    input logic          flush,
    input logic          wb_ex,
    input wb_pkg::word_t flush_pc
);

    allowin_high: assert property (@(posedge clk) disable iff (!resetn) wb_allowin)
        else $error("wb_allowin went low after reset");

    no_write_on_flush: assert property (@(posedge clk) disable iff (!resetn)
        !(flush && debug_wb_rf_we != 4'h0))
        else $error("a register write retired together with a flush");

    // two flushes in a row with the same cause aim at the same target.
    flush_pc_stable: assert property (@(posedge clk) disable iff (!resetn)
        flush && $past(flush) && wb_ex == $past(wb_ex) |-> $stable(flush_pc))
        else $error("flush_pc moved while flush stayed high");

endmodule

bind wb_top wb_top_sva i_wb_top_sva (
    .clk            (clk),
    .resetn         (resetn),
    .wb_allowin     (wb_allowin),
    .debug_wb_rf_we (debug_wb_rf_we),
    .flush          (flush),
    .wb_ex          (wb_ex),
    .flush_pc       (flush_pc)
);

//--- test/wb_top_tb.sv
`timescale 1ns/1ps

module wb_top_tb;
    import wb_pkg::*;

    localparam int save_regs      = 4;
    localparam int n_directed     = 75;
    localparam int n_random       = 150;
    localparam int timeout_cycles = (n_directed + n_random) * 4 + 100;

    typedef struct packed {
        word_t     pc;
        reg_addr_t wnum;
        word_t     wdata;
    } trace_t;

    logic        clk;
    logic        resetn;
    logic        mem_wb_valid;
    mem_wb_bus_t mem_wb_bus;
    logic        wb_allowin;
    wb_id_bus_t  wb_id_bus;
    reg_addr_t   rf_raddr1;
    reg_addr_t   rf_raddr2;
    word_t       rf_rdata1;
    word_t       rf_rdata2;
    word_t       debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    reg_addr_t   debug_wb_rf_wnum;
    word_t       debug_wb_rf_wdata;
    logic        flush;
    word_t       flush_pc;

    word_t       gpr [32];
    word_t       csr_model [64];    // indexed by csr number.
    csr_num_t    csr_list [8];
    trace_t      exp_wr [$];
    word_t       exp_flush [$];
    logic [31:0] lfsr;
    word_t       pc_next;
    int          n_mismatch;
    int          n_other;
    logic        read_set;
    logic        read_armed;
    trace_t      read_next;
    trace_t      read_exp;

    tb_clock i_tb_clock (.*);

    wb_top #(.save_regs(save_regs)) i_wb_top (.*);

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic word_t csr_value(csr_num_t num);
        return (num < 14'd64) ? csr_model[int'(num)] : 32'h0;
    endfunction

    function automatic word_t writable(csr_num_t num);
        if (num == csr_crmd) return 32'h0000_000f;    // plv, ie and da.
        if (num == csr_prmd) return 32'h0000_0007;
        if (num == csr_era) return 32'hffff_ffff;
        if (num == csr_eentry) return 32'hffff_ffc0;
        if (num >= csr_save0 && num < csr_save0 + csr_num_t'(save_regs)) return 32'hffff_ffff;
        return 32'h0;
    endfunction

    function automatic mem_wb_bus_t gpr_item(reg_addr_t dest);
        mem_wb_bus_t b;
        b = '0;
        b.gr_we        = 1'b1;
        b.dest         = dest;
        b.inst         = rand_bits(32);
        b.final_result = rand_bits(32);
        return b;
    endfunction

    function automatic mem_wb_bus_t csr_item(csr_num_t num, logic we);
        mem_wb_bus_t b;
        b = gpr_item(reg_addr_t'(rand_bits(5)));
        b.csr_re     = ~we;
        b.csr_we     = we;
        b.csr_num    = num;
        b.csr_wmask  = rand_bits(32);
        b.csr_wvalue = rand_bits(32);
        return b;
    endfunction

    function automatic mem_wb_bus_t trap_item();
        mem_wb_bus_t b;
        b = csr_item(csr_save0, 1'b1);    // its csr write has to be dropped too.
        b.ex       = 1'b1;
        b.ecode    = ecode_t'(rand_bits(6));
        b.esubcode = esubcode_t'(rand_bits(9));
        return b;
    endfunction

    function automatic mem_wb_bus_t ertn_item();
        mem_wb_bus_t b;
        b = '0;
        b.ertn = 1'b1;
        b.inst = rand_bits(32);
        return b;
    endfunction

    task automatic compare_word(string name, word_t exp, word_t act);
        assert (act === exp) else begin
            n_mismatch++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // drives one item, with an lfsr bubble in front, and updates the model.
    task automatic send(mem_wb_bus_t b);
        word_t m;
        word_t wdata;
        if (rand_bits(2) == 0) begin
            @(posedge clk);
            #1;
            mem_wb_valid = 1'b0;
        end
        @(posedge clk);
        #1;
        b.pc = pc_next;
        pc_next = pc_next + 32'd4;
        mem_wb_valid = 1'b1;
        mem_wb_bus = b;
        wdata = (b.csr_re || b.csr_we) ? csr_value(b.csr_num) : b.final_result;
        if (b.ex) begin
            exp_flush.push_back(csr_value(csr_eentry));
            csr_model[int'(csr_prmd)] = csr_value(csr_crmd) & 32'h7;
            csr_model[int'(csr_crmd)] = csr_value(csr_crmd) & ~32'h7;
            csr_model[int'(csr_era)] = b.pc;
            csr_model[int'(csr_estat)] = {1'b0, b.esubcode, b.ecode, 16'h0};
        end else begin
            if (b.gr_we) begin
                exp_wr.push_back(trace_t'{pc: b.pc, wnum: b.dest, wdata: wdata});
                if (b.dest != 5'd0) gpr[b.dest] = wdata;
            end
            if (b.csr_we && b.csr_num < 14'd64) begin
                m = b.csr_wmask & writable(b.csr_num);
                csr_model[int'(b.csr_num)] = (wdata & ~m) | (b.csr_wvalue & m);
            end
            if (b.ertn) begin
                exp_flush.push_back(csr_value(csr_era));
                csr_model[int'(csr_crmd)] = (csr_value(csr_crmd) & ~32'h7)
                                          | (csr_value(csr_prmd) & 32'h7);
            end
        end
    endtask

    always @(posedge clk) begin
        #1;
        rf_raddr1 = read_next.wnum;
        read_exp = read_next;
        read_armed = read_set;
    end

    initial begin : trace_monitor
        trace_t t;
        forever begin
            @(negedge clk);
            if (resetn) begin
                if (read_armed) compare_word("readback", read_exp.wdata, rf_rdata1);
                read_set = 1'b0;
                if (debug_wb_rf_we != 4'h0 && exp_wr.size() == 0) begin
                    n_other++;
                    $display("register %0d written with no write expected", debug_wb_rf_wnum);
                end else if (debug_wb_rf_we != 4'h0) begin
                    t = exp_wr.pop_front();
                    compare_word("trace we", 32'hf, 32'(debug_wb_rf_we));
                    compare_word("forward we", 32'h1, 32'(wb_id_bus.rf_we));
                    compare_word("trace pc", t.pc, debug_wb_pc);
                    compare_word("trace wnum", 32'(t.wnum), 32'(debug_wb_rf_wnum));
                    compare_word("forward waddr", 32'(t.wnum), 32'(wb_id_bus.rf_waddr));
                    compare_word("trace wdata", t.wdata, debug_wb_rf_wdata);
                    compare_word("forward wdata", t.wdata, wb_id_bus.rf_wdata);
                    read_next = t;
                    if (t.wnum == 5'd0) read_next.wdata = 32'h0;    // r0 stays zero.
                    read_set = 1'b1;
                end else begin
                    compare_word("forward we", 32'h0, 32'(wb_id_bus.rf_we));
                end
                if (flush && exp_flush.size() == 0) begin
                    n_other++;
                    $display("flush raised with no trap or ertn in writeback");
                end else if (flush) begin
                    compare_word("flush_pc", exp_flush.pop_front(), flush_pc);
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d writes and %0d flushes never seen",
                 timeout_cycles, exp_wr.size(), exp_flush.size());
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : stimulus
        mem_wb_bus_t b;
        lfsr = 32'hc0e3_12dd;
        n_mismatch = 0;
        n_other = 0;
        read_set = 1'b0;
        read_armed = 1'b0;
        read_next = '0;
        pc_next = 32'h1c00_0000;
        mem_wb_valid = 1'b0;
        mem_wb_bus = '0;
        rf_raddr1 = '0;
        rf_raddr2 = '0;
        gpr[0] = 32'h0;
        for (int i = 0; i < 64; i++) csr_model[i] = 32'h0;
        csr_model[int'(csr_crmd)] = 32'h8;    // da set out of reset.
        csr_list = '{csr_crmd, csr_prmd, csr_estat, csr_era, csr_eentry, csr_save0,
                     csr_save0 + 14'd3, 14'h3ff};
        @(posedge resetn);
        @(negedge clk);
        compare_word("reset trace we", 32'h0, 32'(debug_wb_rf_we));
        compare_word("reset flush", 32'h0, 32'(flush));
        compare_word("reset forward we", 32'h0, 32'(wb_id_bus.rf_we));
        compare_word("reset allowin", 32'h1, 32'(wb_allowin));
        for (int r = 0; r < 32; r++) send(gpr_item(reg_addr_t'(r)));
        foreach (csr_list[i]) begin
            send(csr_item(csr_list[i], 1'b1));
            send(csr_item(csr_list[i], 1'b0));
        end
        send(csr_item(14'h03f, 1'b1));
        send(csr_item(14'h03f, 1'b0));
        send(csr_item(csr_save0 + 14'd1, 1'b1));
        send(csr_item(csr_save0 + 14'd1, 1'b0));
        send(csr_item(csr_save0 + 14'd2, 1'b1));
        send(csr_item(csr_save0 + 14'd2, 1'b0));
        repeat (3) begin
            send(trap_item());
            send(csr_item(csr_era, 1'b0));
            send(csr_item(csr_estat, 1'b0));
            send(csr_item(csr_prmd, 1'b0));
            send(csr_item(csr_crmd, 1'b0));
            send(ertn_item());
            send(csr_item(csr_crmd, 1'b0));
        end
        repeat (n_random) begin
            case (rand_bits(3))
                5: send(csr_item(csr_list[int'(rand_bits(3))], 1'b1));
                6: send(csr_item(csr_list[int'(rand_bits(3))], 1'b0));
                7: send((rand_bits(1) != 0) ? trap_item() : ertn_item());
                default: begin
                    b = gpr_item(reg_addr_t'(rand_bits(5)));
                    b.gr_we = (rand_bits(3) != 0);
                    send(b);
                end
            endcase
        end
        @(posedge clk);
        #1;
        mem_wb_valid = 1'b0;
        while (exp_wr.size() != 0 || exp_flush.size() != 0) @(negedge clk);
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            #1;
            rf_raddr2 = reg_addr_t'(r);
            @(negedge clk);
            compare_word("register file", gpr[r], rf_rdata2);
        end
        $display("errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
rtl/wb_pkg.sv
rtl/wb_stage.sv
rtl/csr_file.sv
rtl/reg_file.sv
rtl/wb_top.sv
test/tb_clock.sv
test/wb_top_sva.sv
test/wb_top_tb.sv

//--- Makefile
TOP = wb_top_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f list.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
